//--- dv/asym_fifo_chk.sv
`timescale 1ns/100ps

module asym_fifo_chk (
   input  logic                          clk_i,
   input  logic                          rst_n_i,
   input  logic [asym_pkg::W_ADDR_W-1:0] push_addr_o,
   input  logic [asym_pkg::R_ADDR_W-1:0] pop_addr_o,
   input  logic                          w_full_o,
   input  logic                          r_empty_o,
   input  logic [asym_pkg::LEVEL_W-1:0]  r_level_o
);

   import asym_pkg::*;

   // bytes held run from the read pointer up to the next write word
   ptrs_track_level : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      R_ADDR_W'(pop_addr_o + r_level_o) == {push_addr_o, LANE_SEL_W'(0)})
      else $error("read pointer plus level does not reach the write pointer");

   // full means the next write word still holds unread bytes
   full_word_unread : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      w_full_o |-> (pop_addr_o[R_ADDR_W-1:LANE_SEL_W] == push_addr_o))
      else $error("w_full_o set while the next write word is free");

   // empty means the read pointer caught up with the write pointer
   empty_ptrs_equal : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      r_empty_o |-> (pop_addr_o == {push_addr_o, LANE_SEL_W'(0)}))
      else $error("r_empty_o set while the pointers differ");

   level_in_range : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      r_level_o <= LEVEL_W'(FIFO_BYTES))
      else $error("r_level_o above the capacity");

endmodule

bind asym_fifo_ctrl asym_fifo_chk u_chk (
   .clk_i       (clk_i),
   .rst_n_i     (rst_n_i),
   .push_addr_o (push_addr_o),
   .pop_addr_o  (pop_addr_o),
   .w_full_o    (w_full_o),
   .r_empty_o   (r_empty_o),
   .r_level_o   (r_level_o)
);

//--- dv/asym_fifo_tb.sv
`timescale 1ns/100ps

module asym_fifo_tb;

   import asym_pkg::*;

   localparam int CLK_PERIOD = 40;
   localparam int DRIVE_DLY = 2;
   localparam int RESET_CYCLES = 2;
   localparam int DIRECTED_CYCLES = 100;
   localparam int RANDOM_CYCLES = 2000;
   localparam int TOTAL_CYCLES = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES;
   localparam int WATCHDOG_NS = (TOTAL_CYCLES + 100) * CLK_PERIOD;

   // test indices
   localparam int T_RESET = 0;
   localparam int T_ORDER = 1;
   localparam int T_FULL = 2;
   localparam int T_EMPTY = 3;
   localparam int T_RANDOM = 4;
   localparam int T_FLAGS = 5;
   localparam int NUM_TESTS = 6;

   logic                clk;
   logic                rst_n;
   logic                w_en;
   logic [W_DATA_W-1:0] w_data;
   logic                r_en;
   logic [R_DATA_W-1:0] r_data;
   logic                w_full;
   logic                r_empty;
   logic [LEVEL_W-1:0]  r_level;

   // reference model state
   logic [R_DATA_W-1:0] model_q [$];
   logic [R_DATA_W-1:0] last_byte;
   logic                have_last;

   integer seed;
   int     err_cnt [NUM_TESTS];
   int     cur_idx;
   int     flag_idx;
   int     full_seen;
   int     empty_seen;

   asym_fifo_top uut (
      .clk_i     (clk),
      .rst_n_i   (rst_n),
      .w_en_i    (w_en),
      .w_data_i  (w_data),
      .w_full_o  (w_full),
      .r_en_i    (r_en),
      .r_data_o  (r_data),
      .r_empty_o (r_empty),
      .r_level_o (r_level)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic string test_label(input int idx);
      case (idx)
         T_RESET: return "reset";
         T_ORDER: return "byte_order";
         T_FULL: return "full";
         T_EMPTY: return "empty";
         T_RANDOM: return "random";
         default: return "flags";
      endcase
   endfunction

   task automatic compare(input int idx, input string what, input logic [31:0] exp,
                          input logic [31:0] act);
      if (act !== exp) begin
         err_cnt[idx]++;
         $display("** Error [%s] %s: expected %0h, actual %0h", test_label(idx), what, exp, act);
      end
   endtask

   // one clock cycle, entered and left just after the rising edge
   task automatic step(input logic w, input logic [W_DATA_W-1:0] d, input logic r);
      int   level;
      logic push_ok;
      logic pop_ok;
      level = model_q.size();
      compare(flag_idx, "r_level_o", level, r_level);
      compare(flag_idx, "w_full_o", (level > FIFO_BYTES - RATIO), w_full);
      compare(flag_idx, "r_empty_o", (level == 0), r_empty);
      // the last popped byte stays on r_data_o until the next pop
      if (have_last) begin
         compare(cur_idx, "r_data_o", last_byte, r_data);
      end
      if (w_full) begin
         full_seen++;
      end
      if (r_empty) begin
         empty_seen++;
      end
      push_ok = w && !(level > FIFO_BYTES - RATIO);
      pop_ok = r && (level != 0);
      w_en = w;
      w_data = d;
      r_en = r;
      if (pop_ok) begin
         last_byte = model_q.pop_front();
         have_last = 1'b1;
      end
      if (push_ok) begin
         for (int k = 0; k < RATIO; k++) begin
            model_q.push_back(d[k*R_DATA_W +: R_DATA_W]);
         end
      end
      @(posedge clk);
      #(DRIVE_DLY);
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired before the tests finished");
      $display("tests failed");
      $finish;
   end

   initial begin
      int          total;
      logic [31:0] rnd;
      logic        w;
      logic        r;
      seed = 32'hd71fd03a;
      rst_n = 1'b0;
      w_en = 1'b0;
      w_data = '0;
      r_en = 1'b0;
      have_last = 1'b0;
      last_byte = '0;
      full_seen = 0;
      empty_seen = 0;
      for (int i = 0; i < NUM_TESTS; i++) begin
         err_cnt[i] = 0;
      end
      repeat (RESET_CYCLES) @(posedge clk);
      #(DRIVE_DLY);
      rst_n = 1'b1;

      // test 1
      cur_idx = T_RESET;
      flag_idx = T_RESET;
      compare(T_RESET, "r_empty_o", 1, r_empty);
      compare(T_RESET, "w_full_o", 0, w_full);
      compare(T_RESET, "r_level_o", 0, r_level);
      step(1'b0, '0, 1'b0);

      // bytes come out least significant first
      cur_idx = T_ORDER;
      flag_idx = T_ORDER;
      step(1'b1, 32'ha1b2c3d4, 1'b0);
      repeat (RATIO) step(1'b0, '0, 1'b1);
      step(1'b0, '0, 1'b0);

      // fill up, push once too often, then drain
      cur_idx = T_FULL;
      flag_idx = T_FULL;
      repeat (FIFO_BYTES / RATIO) step(1'b1, $random(seed), 1'b0);
      compare(T_FULL, "w_full_o", 1, w_full);
      compare(T_FULL, "r_level_o", FIFO_BYTES, r_level);
      step(1'b1, $random(seed), 1'b0);
      repeat (FIFO_BYTES) step(1'b0, '0, 1'b1);
      step(1'b0, '0, 1'b0);
      compare(T_FULL, "r_level_o", 0, r_level);

      // pops on an empty FIFO change nothing
      cur_idx = T_EMPTY;
      flag_idx = T_EMPTY;
      repeat (5) step(1'b0, '0, 1'b1);
      step(1'b1, $random(seed), 1'b0);
      repeat (RATIO) step(1'b0, '0, 1'b1);
      step(1'b0, '0, 1'b0);

      // random traffic where fill and drain phases take turns
      cur_idx = T_RANDOM;
      flag_idx = T_FLAGS;
      full_seen = 0;
      empty_seen = 0;
      for (int i = 0; i < RANDOM_CYCLES; i++) begin
         rnd = $random(seed);
         if (((i / 250) % 2) == 0) begin
            w = (rnd[3:0] < 4'd8);
         end else begin
            w = (rnd[3:0] < 4'd2);
         end
         r = (rnd[7:4] < 4'd14);
         step(w, $random(seed), r);
      end
      if (full_seen == 0) begin
         err_cnt[T_RANDOM]++;
         $display("random traffic never reached the full state");
      end
      if (empty_seen == 0) begin
         err_cnt[T_RANDOM]++;
         $display("random traffic never reached the empty state");
      end

      total = 0;
      for (int i = 0; i < NUM_TESTS; i++) begin
         total += err_cnt[i];
      end
      $display("errors: reset=%0d byte_order=%0d full=%0d empty=%0d random=%0d flags=%0d",
               err_cnt[T_RESET], err_cnt[T_ORDER], err_cnt[T_FULL], err_cnt[T_EMPTY],
               err_cnt[T_RANDOM], err_cnt[T_FLAGS]);
      if (total == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

//--- files.f
hdl/asym_pkg.sv
hdl/asym_fifo_ctrl.sv
hdl/asym_converter.sv
hdl/asym_lane_ram.sv
hdl/asym_fifo_top.sv
dv/asym_fifo_chk.sv
dv/asym_fifo_tb.sv

//--- hdl/asym_converter.sv
`timescale 1ns/100ps

module asym_converter (
   input  logic                          clk_i,
   input  logic                          rst_n_i,

   // word write request
   input  logic                          push_i,
   input  logic [asym_pkg::W_ADDR_W-1:0] push_addr_i,
   input  logic [asym_pkg::W_DATA_W-1:0] push_data_i,

   // byte read request
   input  logic                          pop_i,
   input  logic [asym_pkg::R_ADDR_W-1:0] pop_addr_i,

   // lane memory side
   output asym_pkg::lane_wr_t            lane_wr_o,
   output asym_pkg::lane_rd_t            lane_rd_o,
   input  logic [asym_pkg::W_DATA_W-1:0] lane_rdata_i,

   // popped byte
   output logic [asym_pkg::R_DATA_W-1:0] r_data_o
);

   import asym_pkg::*;

   logic [LANE_SEL_W-1:0] pop_lane;
   logic [LANE_SEL_W-1:0] lane_sel_q;
   logic [W_DATA_W-1:0]   rdata_shifted;

   // a word spans all lanes at the same lane address
   assign lane_wr_o.en   = {RATIO{push_i}};
   assign lane_wr_o.addr = push_addr_i;
   assign lane_wr_o.data = push_data_i;

   // low bits of the byte address pick the lane
   assign pop_lane = pop_addr_i[LANE_SEL_W-1:0];

   // only the addressed lane reads, the others keep their output
   assign lane_rd_o.en   = {{(RATIO - 1){1'b0}}, pop_i} << pop_lane;
   assign lane_rd_o.addr = pop_addr_i[R_ADDR_W-1:LANE_SEL_W];

   // captured with the RAM read so both line up next cycle
   // held between pops so r_data_o stays on the last byte
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         lane_sel_q <= '0;
      end else if (pop_i) begin
         lane_sel_q <= pop_lane;
      end
   end

   // move the selected lane down to the bottom byte
   assign rdata_shifted = lane_rdata_i >> (lane_sel_q * R_DATA_W);
   assign r_data_o      = rdata_shifted[R_DATA_W-1:0];

endmodule

//--- hdl/asym_fifo_ctrl.sv
`timescale 1ns/100ps

module asym_fifo_ctrl (
   input  logic                          clk_i,
   input  logic                          rst_n_i,

   // raw requests from outside
   input  logic                          w_en_i,
   input  logic                          r_en_i,

   // accepted push, word addressed
   output logic                          push_o,
   output logic [asym_pkg::W_ADDR_W-1:0] push_addr_o,

   // accepted pop, byte addressed
   output logic                          pop_o,
   output logic [asym_pkg::R_ADDR_W-1:0] pop_addr_o,

   // status
   output logic                          w_full_o,
   output logic                          r_empty_o,
   output logic [asym_pkg::LEVEL_W-1:0]  r_level_o
);

   import asym_pkg::*;

   // a push adds a whole word of bytes, a pop takes one byte
   localparam logic [LEVEL_W-1:0] PUSH_INC = LEVEL_W'(RATIO);
   localparam logic [LEVEL_W-1:0] POP_DEC = LEVEL_W'(1);

   // above this level a whole word no longer fits
   localparam logic [LEVEL_W-1:0] FULL_LIMIT = LEVEL_W'(FIFO_BYTES - RATIO);

   logic [W_ADDR_W-1:0] wr_ptr_q;
   logic [R_ADDR_W-1:0] rd_ptr_q;
   logic [LEVEL_W-1:0]  level_q;
   logic [LEVEL_W-1:0]  level_d;

   logic full;
   logic empty;
   logic push;
   logic pop;

   // flags come straight from the level register
   assign full  = (level_q > FULL_LIMIT);
   assign empty = (level_q == '0);

   // strobes are gated here only
   assign push = w_en_i & ~full;
   assign pop  = r_en_i & ~empty;

   // push and pop may both land in one cycle
   always_comb begin
      level_d = level_q;
      if (push) begin
         level_d = level_d + PUSH_INC;
      end
      if (pop) begin
         level_d = level_d - POP_DEC;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         level_q <= '0;
      end else begin
         level_q <= level_d;
      end
   end

   // word pointer, wraps at the capacity by its width
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
      end else if (push) begin
         wr_ptr_q <= wr_ptr_q + 1'b1;
      end
   end

   // byte pointer, same wrap point as the word pointer
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rd_ptr_q <= '0;
      end else if (pop) begin
         rd_ptr_q <= rd_ptr_q + 1'b1;
      end
   end

   // towards the converter
   assign push_o      = push;
   assign push_addr_o = wr_ptr_q;
   assign pop_o       = pop;
   assign pop_addr_o  = rd_ptr_q;

   // towards the outside
   assign w_full_o  = full;
   assign r_empty_o = empty;
   assign r_level_o = level_q;

endmodule

//--- hdl/asym_fifo_top.sv
`timescale 1ns/100ps

module asym_fifo_top (
   input  logic                          clk_i,
   input  logic                          rst_n_i,

   // word write side
   input  logic                          w_en_i,
   input  logic [asym_pkg::W_DATA_W-1:0] w_data_i,
   output logic                          w_full_o,

   // byte read side
   input  logic                          r_en_i,
   output logic [asym_pkg::R_DATA_W-1:0] r_data_o,
   output logic                          r_empty_o,
   output logic [asym_pkg::LEVEL_W-1:0]  r_level_o
);

   import asym_pkg::*;

   // accepted strobes and their addresses
   logic                push;
   logic [W_ADDR_W-1:0] push_addr;
   logic                pop;
   logic [R_ADDR_W-1:0] pop_addr;

   // lane memory ports
   lane_wr_t            lane_wr;
   lane_rd_t            lane_rd;
   logic [W_DATA_W-1:0] lane_rdata;

   asym_fifo_ctrl u_ctrl (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .w_en_i      (w_en_i),
      .r_en_i      (r_en_i),
      .push_o      (push),
      .push_addr_o (push_addr),
      .pop_o       (pop),
      .pop_addr_o  (pop_addr),
      .w_full_o    (w_full_o),
      .r_empty_o   (r_empty_o),
      .r_level_o   (r_level_o)
   );

   asym_converter u_conv (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .push_i       (push),
      .push_addr_i  (push_addr),
      .push_data_i  (w_data_i),
      .pop_i        (pop),
      .pop_addr_i   (pop_addr),
      .lane_wr_o    (lane_wr),
      .lane_rd_o    (lane_rd),
      .lane_rdata_i (lane_rdata),
      .r_data_o     (r_data_o)
   );

   // storage, four byte lanes
   asym_lane_ram u_ram (
      .clk_i        (clk_i),
      .lane_wr_i    (lane_wr),
      .lane_rd_i    (lane_rd),
      .lane_rdata_o (lane_rdata)
   );

endmodule

//--- hdl/asym_lane_ram.sv
`timescale 1ns/100ps

module asym_lane_ram (
   input  logic                          clk_i,

   // write and read ports, one enable per lane
   input  asym_pkg::lane_wr_t            lane_wr_i,
   input  asym_pkg::lane_rd_t            lane_rd_i,

   // registered read data of all lanes, lane k in bits 8k +: 8
   output logic [asym_pkg::W_DATA_W-1:0] lane_rdata_o
);

   import asym_pkg::*;

   localparam int LANE_DEPTH = 2 ** LANE_ADDR_W;

   for (genvar k = 0; k < RATIO; k++) begin : g_lane
      logic [R_DATA_W-1:0] mem [LANE_DEPTH];
      logic [R_DATA_W-1:0] rdata_q;

      // each lane stores its own byte of the word
      always_ff @(posedge clk_i) begin
         if (lane_wr_i.en[k]) begin
            mem[lane_wr_i.addr] <= lane_wr_i.data[k*R_DATA_W +: R_DATA_W];
         end
      end

      // synchronous read, output holds while the lane is idle
      always_ff @(posedge clk_i) begin
         if (lane_rd_i.en[k]) begin
            rdata_q <= mem[lane_rd_i.addr];
         end
      end

      assign lane_rdata_o[k*R_DATA_W +: R_DATA_W] = rdata_q;
   end

endmodule

//--- hdl/asym_pkg.sv
package asym_pkg;

   // write side is the wide side, read side the narrow one
   localparam int W_DATA_W = 32;
   localparam int R_DATA_W = 8;

   // read words per write word, one lane per read word
   localparam int RATIO = W_DATA_W / R_DATA_W;
   localparam int LANE_SEL_W = $clog2(RATIO);

   // byte addressing on the read side
   localparam int R_ADDR_W = 6;
   // word addressing on the write side
   localparam int W_ADDR_W = R_ADDR_W - LANE_SEL_W;
   // every lane is one byte of a word, so it is indexed by the word address
   localparam int LANE_ADDR_W = W_ADDR_W;

   // capacity in bytes
   localparam int FIFO_BYTES = 2 ** R_ADDR_W;
   // level has to reach FIFO_BYTES itself, hence one extra bit
   localparam int LEVEL_W = R_ADDR_W + 1;

   // write port of the lane memory
   // lane k takes data[8k +: 8]
   typedef struct packed {
      logic [RATIO-1:0]       en;
      logic [LANE_ADDR_W-1:0] addr;
      logic [W_DATA_W-1:0]    data;
   } lane_wr_t;

   // read port of the lane memory
   // at most one enable bit is set per cycle
   typedef struct packed {
      logic [RATIO-1:0]       en;
      logic [LANE_ADDR_W-1:0] addr;
   } lane_rd_t;

endpackage
